// ==== design/pixel_mixer.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_mixer import step_game_pkg::*; (
	input  logic       clk,
	input  logic       arst_n,
	input  tile_kind_t step_type,
	input  logic       tile_edge,
	input  logic       player_hit,
	output rgb332_t    rgb,
	output logic       death_touch
);

	rgb332_t tile_color;
	rgb332_t next_rgb;
	logic    next_death;

	//////////////////////////////////////////////////
	// palette lookup
	//////////////////////////////////////////////////

	// each tile kind has one fixed colour.
	// the unused codes fall back to the background.
	always_comb begin
		case (step_type)
			TILE_REGU:  tile_color = COLOR_REGU;
			TILE_GATE:  tile_color = COLOR_GATE;
			TILE_DEATH: tile_color = COLOR_DEATH;
			default:    tile_color = COLOR_BACK;
		endcase
	end

	//////////////////////////////////////////////////
	// priority
	//////////////////////////////////////////////////

	// the player is drawn over everything, and tile lines over the tile fill.
	always_comb begin
		if (player_hit) begin
			next_rgb = COLOR_PLAYER;
		end else if (tile_edge) begin
			next_rgb = COLOR_EDGE;
		end else begin
			next_rgb = tile_color;
		end
	end

	// contact counts only where a drawn player pixel covers a death tile.
	assign next_death = player_hit && (step_type == TILE_DEATH);

	// output stage, two clocks after the coordinates entered the top level.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rgb         <= COLOR_BACK;
			death_touch <= 1'b0;
		end else begin
			rgb         <= next_rgb;
			death_touch <= next_death;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// a death contact is always a pixel painted in the player colour.
	a_death_is_player: assert property (@(posedge clk) disable iff (!arst_n)
		death_touch |-> (rgb == COLOR_PLAYER));

endmodule

`default_nettype wire

// ==== design/player_sprite.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "step_game_params.svh"

module player_sprite (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [10:0] pixel_x,
	input  logic [10:0] pixel_y,
	input  logic        move_left,
	input  logic        move_right,
	input  logic        move_up,
	input  logic        move_down,
	output logic        player_hit
);

	// the square's top-left corner may range over the grid minus one square.
	localparam logic [10:0] X_MAX = 11'((`GRID_COLS << `TILE_SHIFT) - `PLAYER_SIZE);
	localparam logic [10:0] Y_MAX = 11'((`GRID_ROWS << `TILE_SHIFT) - `PLAYER_SIZE);
	localparam logic [10:0] STEP  = 11'(`PLAYER_STEP);
	localparam logic [10:0] SPAN  = 11'(`PLAYER_SIZE - 1);

	logic [10:0] pos_x;
	logic [10:0] pos_y;
	logic [10:0] next_x;
	logic [10:0] next_y;
	logic        hit_x;
	logic        hit_y;

	//////////////////////////////////////////////////
	// movement with clamping
	//////////////////////////////////////////////////

	// opposite pulses cancel, so only a lone pulse moves the square.
	// a step that would cross a limit lands exactly on that limit.
	always_comb begin
		next_x = pos_x;
		if (move_left && !move_right) begin
			next_x = (pos_x < STEP) ? 11'd0 : pos_x - STEP;
		end else if (move_right && !move_left) begin
			next_x = (pos_x > X_MAX - STEP) ? X_MAX : pos_x + STEP;
		end
	end

	// the vertical axis follows the same rule, with y growing downwards.
	always_comb begin
		next_y = pos_y;
		if (move_up && !move_down) begin
			next_y = (pos_y < STEP) ? 11'd0 : pos_y - STEP;
		end else if (move_down && !move_up) begin
			next_y = (pos_y > Y_MAX - STEP) ? Y_MAX : pos_y + STEP;
		end
	end

	//////////////////////////////////////////////////
	// hit test
	//////////////////////////////////////////////////

	// the square spans its corner plus PLAYER_SIZE minus one on each axis.
	assign hit_x = (pixel_x >= pos_x) && (pixel_x <= pos_x + SPAN);
	assign hit_y = (pixel_y >= pos_y) && (pixel_y <= pos_y + SPAN);

	// the hit is taken against the position held before this edge's move.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pos_x      <= 11'(`PLAYER_X0);
			pos_y      <= 11'(`PLAYER_Y0);
			player_hit <= 1'b0;
		end else begin
			pos_x      <= next_x;
			pos_y      <= next_y;
			player_hit <= hit_x && hit_y;
		end
	end

	// whatever the pulse history, the square never leaves the grid.
	a_in_limits: assert property (@(posedge clk) disable iff (!arst_n)
		(pos_x <= X_MAX) && (pos_y <= Y_MAX));

endmodule

`default_nettype wire

// ==== design/step_controller.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "step_game_params.svh"

module step_controller import step_game_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [10:0] pixel_x,
	input  logic [10:0] pixel_y,
	input  logic        gate,
	output tile_kind_t  step_type,
	output logic        tile_edge
);

	// the grid covers 640 by 448 pixels, the rest of the picture is empty.
	localparam int GRID_W = `GRID_COLS << `TILE_SHIFT;
	localparam int GRID_H = `GRID_ROWS << `TILE_SHIFT;
	localparam int COL_W  = $clog2(`GRID_COLS);
	localparam int ROW_W  = $clog2(`GRID_ROWS);
	localparam int ROW_BITS = 3 * `GRID_COLS;

	// the constant map, one packed word per row.
	localparam logic [ROW_BITS-1:0] MAP_INIT [`GRID_ROWS] = '{
		`MAP_ROW0, `MAP_ROW1, `MAP_ROW2, `MAP_ROW3,
		`MAP_ROW4, `MAP_ROW5, `MAP_ROW6
	};

	tile_kind_t tile_map [`GRID_ROWS][`GRID_COLS];

	logic             inside_grid;
	logic [COL_W-1:0] col_idx;
	logic [ROW_W-1:0] row_idx;
	logic             on_tile_line;
	tile_kind_t       cur_kind;

	//////////////////////////////////////////////////
	// map storage and gate update
	//////////////////////////////////////////////////

	// reset reloads the whole map, so an opened gate closes again.
	// a gate pulse only touches its one entry and all others keep their code.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < `GRID_ROWS; r++) begin
				for (int c = 0; c < `GRID_COLS; c++) begin
					tile_map[r][c] <= tile_kind_t'(MAP_INIT[r][3*(`GRID_COLS-1-c) +: 3]);
				end
			end
		end else if (gate) begin
			tile_map[`GATE_ROW][`GATE_COL] <= TILE_GATE;
		end
	end

	//////////////////////////////////////////////////
	// lookup
	//////////////////////////////////////////////////

	// inside the grid the upper coordinate bits are zero, so the narrow
	// index fields below are exact tile numbers.
	assign inside_grid = (pixel_x < 11'(GRID_W)) && (pixel_y < 11'(GRID_H));
	assign col_idx     = pixel_x[`TILE_SHIFT +: COL_W];
	assign row_idx     = pixel_y[`TILE_SHIFT +: ROW_W];

	// a pixel is on the top or left line of its tile when either offset is zero.
	assign on_tile_line = (pixel_x[`TILE_SHIFT-1:0] == '0) ||
		(pixel_y[`TILE_SHIFT-1:0] == '0);

	// everything beyond the grid reads as free ground.
	assign cur_kind = inside_grid ? tile_map[row_idx][col_idx] : TILE_FREE;

	// the lookup sees the map as it was before this edge, so a gate pulse
	// shows up for coordinates sampled one clock later.
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			step_type <= TILE_FREE;
			tile_edge <= 1'b0;
		end else begin
			step_type <= cur_kind;
			tile_edge <= on_tile_line && (cur_kind != TILE_FREE);
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// the map only ever holds the four defined codes, so neither reset
	// nor a gate write may leave an unused code in the output.
	a_known_kind: assert property (@(posedge clk) disable iff (!arst_n)
		step_type inside {TILE_FREE, TILE_REGU, TILE_GATE, TILE_DEATH});

endmodule

`default_nettype wire

// ==== design/step_game_params.svh ====
`ifndef STEP_GAME_PARAMS_SVH
`define STEP_GAME_PARAMS_SVH

// tiles are square, and their side is a power of two.
`define TILE_SHIFT 6
`define GRID_COLS 10
`define GRID_ROWS 7

// the player is a plain square moved in fixed steps.
`define PLAYER_SIZE 16
`define PLAYER_STEP 4
`define PLAYER_X0 64
`define PLAYER_Y0 64

// the one tile that a gate pulse turns into a gate.
`define GATE_ROW 4
`define GATE_COL 6

// one octal digit per tile, column 0 leftmost (free 0, regular 1, gate 2, death 3).
// the gate tile at row 4 column 6 starts out free.
`define MAP_ROW0 30'o0000000000
`define MAP_ROW1 30'o1000100000
`define MAP_ROW2 30'o0010000000
`define MAP_ROW3 30'o0101010101
`define MAP_ROW4 30'o0000000000
`define MAP_ROW5 30'o1000000010
`define MAP_ROW6 30'o0111213131

`endif

// ==== design/step_game_pkg.sv ====
`default_nettype none

package step_game_pkg;

	//////////////////////////////////////////////////
	// tile codes
	//////////////////////////////////////////////////

	// codes 4 to 7 never appear in the map.
	typedef enum logic [2:0] {
		TILE_FREE  = 3'd0,
		TILE_REGU  = 3'd1,
		TILE_GATE  = 3'd2,
		TILE_DEATH = 3'd3
	} tile_kind_t;

	//////////////////////////////////////////////////
	// palette
	//////////////////////////////////////////////////

	// the colour word is red 3 bits, green 3 bits, blue 2 bits, from the top.
	typedef logic [7:0] rgb332_t;

	localparam rgb332_t COLOR_BACK   = 8'h00;
	localparam rgb332_t COLOR_REGU   = 8'h6D;
	localparam rgb332_t COLOR_GATE   = 8'h1C;
	localparam rgb332_t COLOR_DEATH  = 8'hE0;
	localparam rgb332_t COLOR_EDGE   = 8'h92;
	localparam rgb332_t COLOR_PLAYER = 8'hFF;

endpackage

`default_nettype wire

// ==== design/step_game_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module step_game_top import step_game_pkg::*; (
	input  logic        clk,
	input  logic        arst_n,
	input  logic [10:0] pixel_x,
	input  logic [10:0] pixel_y,
	input  logic        gate,
	input  logic        move_left,
	input  logic        move_right,
	input  logic        move_up,
	input  logic        move_down,
	output rgb332_t     rgb,
	output logic        death_touch
);

	// first stage results, all aligned to the same sampled pixel.
	tile_kind_t step_type;
	logic       tile_edge;
	logic       player_hit;

	//////////////////////////////////////////////////
	// first stage
	//////////////////////////////////////////////////

	// the map lookup and the player test run side by side on each pixel.
	step_controller u_step_controller (
		.clk       (clk),
		.arst_n    (arst_n),
		.pixel_x   (pixel_x),
		.pixel_y   (pixel_y),
		.gate      (gate),
		.step_type (step_type),
		.tile_edge (tile_edge)
	);

	player_sprite u_player_sprite (
		.clk        (clk),
		.arst_n     (arst_n),
		.pixel_x    (pixel_x),
		.pixel_y    (pixel_y),
		.move_left  (move_left),
		.move_right (move_right),
		.move_up    (move_up),
		.move_down  (move_down),
		.player_hit (player_hit)
	);

	//////////////////////////////////////////////////
	// second stage
	//////////////////////////////////////////////////

	// the mixer turns both results into the final colour.
	pixel_mixer u_pixel_mixer (
		.clk         (clk),
		.arst_n      (arst_n),
		.step_type   (step_type),
		.tile_edge   (tile_edge),
		.player_hit  (player_hit),
		.rgb         (rgb),
		.death_touch (death_touch)
	);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the step_game simulation with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f step_game.f \
	--top-module step_game_tb \
	-o step_game_sim

output="$(./obj_dir/step_game_sim)"
echo "$output"

if grep -q "Verification passed" <<< "$output"; then
	exit 0
fi
exit 1

// ==== step_game.f ====
+incdir+design
design/step_game_pkg.sv
design/step_controller.sv
design/player_sprite.sv
design/pixel_mixer.sv
design/step_game_top.sv
testbench/step_game_tb.sv

// ==== testbench/step_game_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "step_game_params.svh"

module step_game_tb import step_game_pkg::*; ();

	localparam int TILE = 1 << `TILE_SHIFT;
	localparam int GRID_W = `GRID_COLS * TILE;
	localparam int GRID_H = `GRID_ROWS * TILE;
	localparam int X_MAX = GRID_W - `PLAYER_SIZE;
	localparam int Y_MAX = GRID_H - `PLAYER_SIZE;

	// test lengths in clock cycles, summed up for the watchdog.
	localparam int N_BURSTS = 20;
	localparam int BURST_LEN = 16;
	localparam int CLAMP_RUN = 170;
	localparam int N_RANDOM = 10000;
	localparam int N_SWEEP = 2 * `GRID_ROWS * `GRID_COLS;
	localparam int N_OTHER = 400;
	localparam int STIM_CYCLES = N_SWEEP + N_BURSTS * (BURST_LEN + 8) +
		4 * (CLAMP_RUN + 8) + N_RANDOM + N_OTHER;

	// direction pulses packed as {left, right, up, down}.
	localparam logic [3:0] MV_NONE = 4'b0000;
	localparam logic [3:0] MV_LEFT = 4'b1000;
	localparam logic [3:0] MV_RIGHT = 4'b0100;
	localparam logic [3:0] MV_UP = 4'b0010;
	localparam logic [3:0] MV_DOWN = 4'b0001;

	logic clk;
	logic arst_n;
	logic [10:0] pixel_x;
	logic [10:0] pixel_y;
	logic gate;
	logic move_left;
	logic move_right;
	logic move_up;
	logic move_down;
	rgb332_t rgb;
	logic death_touch;

	// model state: the tile map, the player corner and the random generator.
	logic [2:0] model_map [`GRID_ROWS][`GRID_COLS];
	int model_x;
	int model_y;
	logic [31:0] rng = 32'h2e33;
	logic [8:0] exp_q [$];
	logic [8:0] cmp_exp;
	int checks = 0;
	int errors = 0;

	step_game_top dut0 (
		.clk         (clk),
		.arst_n      (arst_n),
		.pixel_x     (pixel_x),
		.pixel_y     (pixel_y),
		.gate        (gate),
		.move_left   (move_left),
		.move_right  (move_right),
		.move_up     (move_up),
		.move_down   (move_down),
		.rgb         (rgb),
		.death_touch (death_touch)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////////////////////////////////////
	// reference model
	////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic logic [29:0] map_row(input int r);
		case (r)
			0: return `MAP_ROW0;
			1: return `MAP_ROW1;
			2: return `MAP_ROW2;
			3: return `MAP_ROW3;
			4: return `MAP_ROW4;
			5: return `MAP_ROW5;
			default: return `MAP_ROW6;
		endcase
	endfunction

	// column 0 sits in the top three bits of each row word.
	task automatic model_reset();
		logic [29:0] word;
		for (int r = 0; r < `GRID_ROWS; r++) begin
			word = map_row(r);
			for (int c = 0; c < `GRID_COLS; c++) begin
				model_map[r][c] = word[3*(`GRID_COLS-1-c) +: 3];
			end
		end
		model_x = `PLAYER_X0;
		model_y = `PLAYER_Y0;
	endtask

	// one axis of the player; opposite pulses cancel and steps stop at the limits.
	function automatic int step_axis(input int pos, input logic dec, input logic inc,
		input int lim);
		if (dec && !inc) begin
			return (pos < `PLAYER_STEP) ? 0 : pos - `PLAYER_STEP;
		end else if (inc && !dec) begin
			return (pos + `PLAYER_STEP > lim) ? lim : pos + `PLAYER_STEP;
		end
		return pos;
	endfunction

	// returns {death_touch, rgb} for one pixel against the model map and player.
	function automatic logic [8:0] expected_pixel(input logic [10:0] x, input logic [10:0] y,
		input int px, input int py);
		int xi;
		int yi;
		logic [2:0] kind;
		logic on_edge;
		logic hit;
		rgb332_t color;
		xi = int'(x);
		yi = int'(y);
		kind = 3'd0;
		if (xi < GRID_W && yi < GRID_H) begin
			kind = model_map[yi / TILE][xi / TILE];
		end
		on_edge = (kind != 3'd0) && ((xi % TILE == 0) || (yi % TILE == 0));
		hit = (xi >= px) && (xi <= px + `PLAYER_SIZE - 1) &&
			(yi >= py) && (yi <= py + `PLAYER_SIZE - 1);
		case (kind)
			3'd1: color = COLOR_REGU;
			3'd2: color = COLOR_GATE;
			3'd3: color = COLOR_DEATH;
			default: color = COLOR_BACK;
		endcase
		if (hit) color = COLOR_PLAYER;
		else if (on_edge) color = COLOR_EDGE;
		return {hit && (kind == 3'd3), color};
	endfunction

	////////////////////////////////////////////////////
	// stimulus and compare
	////////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
		end
	endtask

	// the expectation is taken with the state the DUT sees at the next rising edge,
	// and the model then moves on exactly as the DUT does at that edge.
	task automatic drive_cycle(input logic [10:0] x, input logic [10:0] y, input logic g,
		input logic [3:0] mv);
		@(negedge clk);
		pixel_x = x;
		pixel_y = y;
		gate = g;
		{move_left, move_right, move_up, move_down} = mv;
		exp_q.push_back(expected_pixel(x, y, model_x, model_y));
		if (g) model_map[`GATE_ROW][`GATE_COL] = 3'd2;
		model_x = step_axis(model_x, mv[3], mv[2], X_MAX);
		model_y = step_axis(model_y, mv[1], mv[0], Y_MAX);
	endtask

	// two idle pixels push the last real ones out before reset.
	task automatic apply_reset();
		drive_cycle(11'd2047, 11'd2047, 1'b0, MV_NONE);
		drive_cycle(11'd2047, 11'd2047, 1'b0, MV_NONE);
		@(negedge clk);
		arst_n = 1'b0;
		repeat (3) @(negedge clk);
		arst_n = 1'b1;
		exp_q.delete();
		model_reset();
	endtask

	// the four corners of the square and one pixel just beyond each of them.
	task automatic probe_square();
		drive_cycle(11'(model_x), 11'(model_y), 1'b0, MV_NONE);
		drive_cycle(11'(model_x + 15), 11'(model_y), 1'b0, MV_NONE);
		drive_cycle(11'(model_x), 11'(model_y + 15), 1'b0, MV_NONE);
		drive_cycle(11'(model_x + 15), 11'(model_y + 15), 1'b0, MV_NONE);
		drive_cycle(11'(model_x - 1), 11'(model_y), 1'b0, MV_NONE);
		drive_cycle(11'(model_x + 16), 11'(model_y + 15), 1'b0, MV_NONE);
		drive_cycle(11'(model_x), 11'(model_y - 1), 1'b0, MV_NONE);
		drive_cycle(11'(model_x + 15), 11'(model_y + 16), 1'b0, MV_NONE);
	endtask

	// outputs trail the driven pixel by two edges, so the front entry is due
	// once a second one stands behind it.
	always @(posedge clk) begin
		#1;
		if (arst_n && exp_q.size() >= 2) begin
			cmp_exp = exp_q.pop_front();
			check_value("rgb", 32'(rgb), 32'(cmp_exp[7:0]));
			check_value("death_touch", 32'(death_touch), 32'(cmp_exp[8]));
		end
	end

	initial begin
		#((STIM_CYCLES + 100) * 8);
		$display("watchdog expired before the stimulus finished");
		$display("Verification failed");
		$finish;
	end

	initial begin
		arst_n = 1'b0;
		pixel_x = '0;
		pixel_y = '0;
		gate = 1'b0;
		{move_left, move_right, move_up, move_down} = MV_NONE;
		model_reset();
		repeat (3) @(negedge clk);
		arst_n = 1'b1;

		// top-left pixel and one interior pixel of every tile.
		for (int r = 0; r < `GRID_ROWS; r++) begin
			for (int c = 0; c < `GRID_COLS; c++) begin
				drive_cycle(11'(c * TILE), 11'(r * TILE), 1'b0, MV_NONE);
				drive_cycle(11'(c * TILE + 37), 11'(r * TILE + 21), 1'b0, MV_NONE);
			end
		end

		// pixels right of and below the grid, some so far out that their
		// low coordinate bits point back into the map.
		for (int i = 0; i < 8; i++) begin
			rng = xorshift(rng);
			drive_cycle(11'(GRID_W + i * 200), {2'b0, rng[8:0]}, 1'b0, MV_NONE);
			drive_cycle({1'b0, rng[18:9]}, 11'(GRID_H + i * 200), 1'b0, MV_NONE);
		end

		// gate tile interior before the pulse, on the pulse, after it, and after reset.
		drive_cycle(11'(`GATE_COL * TILE + 30), 11'(`GATE_ROW * TILE + 30), 1'b0, MV_NONE);
		drive_cycle(11'(`GATE_COL * TILE + 30), 11'(`GATE_ROW * TILE + 30), 1'b1, MV_NONE);
		drive_cycle(11'(`GATE_COL * TILE + 30), 11'(`GATE_ROW * TILE + 30), 1'b0, MV_NONE);
		apply_reset();
		drive_cycle(11'(`GATE_COL * TILE + 30), 11'(`GATE_ROW * TILE + 30), 1'b0, MV_NONE);

		// random bursts of direction pulses, then a look at the square.
		for (int b = 0; b < N_BURSTS; b++) begin
			for (int i = 0; i < BURST_LEN; i++) begin
				rng = xorshift(rng);
				drive_cycle({1'b0, rng[9:0]}, {2'b0, rng[18:10]}, 1'b0, rng[23:20]);
			end
			probe_square();
		end

		// long runs against all four limits.
		repeat (CLAMP_RUN) drive_cycle(11'd2047, 11'd0, 1'b0, MV_LEFT);
		probe_square();
		repeat (CLAMP_RUN) drive_cycle(11'd2047, 11'd0, 1'b0, MV_UP);
		probe_square();
		repeat (CLAMP_RUN) drive_cycle(11'd2047, 11'd0, 1'b0, MV_RIGHT);
		probe_square();
		repeat (CLAMP_RUN) drive_cycle(11'd2047, 11'd0, 1'b0, MV_DOWN);
		probe_square();

		// walk onto the death tile at row 6 column 6, then onto the regular one beside it.
		while (model_x != 6 * TILE + 24) begin
			drive_cycle(11'd2047, 11'd0, 1'b0, (model_x > 6 * TILE + 24) ? MV_LEFT : MV_RIGHT);
		end
		while (model_y != 6 * TILE + 24) begin
			drive_cycle(11'd2047, 11'd0, 1'b0, (model_y > 6 * TILE + 24) ? MV_UP : MV_DOWN);
		end
		drive_cycle(11'(model_x + 1), 11'(model_y + 1), 1'b0, MV_NONE);
		drive_cycle(11'(model_x + 9), 11'(model_y + 7), 1'b0, MV_NONE);
		probe_square();
		repeat (16) drive_cycle(11'd2047, 11'd0, 1'b0, MV_RIGHT);
		probe_square();

		// random mixes, half of them aimed at the area around the player.
		for (int i = 0; i < N_RANDOM; i++) begin
			rng = xorshift(rng);
			if (rng[19]) begin
				drive_cycle(11'(model_x + int'(rng[4:0]) - 8), 11'(model_y + int'(rng[9:5]) - 8),
					rng[31:28] == 4'hf, rng[27:24] & {4{rng[20]}});
			end else begin
				drive_cycle({1'b0, rng[9:0]}, {2'b0, rng[18:10]},
					rng[31:28] == 4'hf, rng[27:24] & {4{rng[20]}});
			end
		end

		drive_cycle(11'd2047, 11'd2047, 1'b0, MV_NONE);
		drive_cycle(11'd2047, 11'd2047, 1'b0, MV_NONE);
		@(posedge clk);
		#2;
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
